// File: Makefile
TOP := mcuResourcesTb

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f tb.f --top-module $(TOP) -Mdir obj_dir -o V$(TOP)
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing --assert -Wall --timescale 1ns/100ps \
		-f tb.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: dv/mcuResourcesTb.sv
module mcuResourcesTb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int MAX_OPS = 64;
	localparam int CYCLES_PER_OP = 200;

	typedef enum logic [3:0] {
		OP_END = 4'd0,
		OP_WR_WORD = 4'd1,
		OP_WR_LOW = 4'd2,
		OP_WR_HIGH = 4'd3,
		OP_READ = 4'd4,
		OP_SET_INTS = 4'd5,
		OP_SET_EXT = 4'd6,
		OP_CHECK_IRQ = 4'd7,
		OP_WAIT = 4'd8,
		OP_POLL = 4'd9
	} op_t;

	// One line of the stimulus file
	typedef struct packed {
		logic [3:0] op;
		logic [15:0] addr;
		logic [15:0] data;
		logic [15:0] expected;
	} stimOp_t;

	logic CLK;
	logic arstN;
	logic [15:0] addr;
	logic [15:0] cpuDout;
	logic [15:0] cpuDin;
	logic rdN;
	logic wr0N;
	logic wr1N;
	logic [15:0] dinBus;
	logic [15:0] dinGpio;
	logic rdGpio;
	logic wrGpio;
	logic [1:0] addrGpio;
	logic uartLine;
	logic [6:0] ints;
	logic int0;
	logic int1;

	logic [$bits(stimOp_t)-1:0] stimMem [MAX_OPS];
	int cycles = 0;
	int cycleLimit = 0;

	tbClock tbClock_i (
		.CLK(CLK),
		.arstN(arstN)
	);

	// Transmit line loops straight back into the receiver
	mcuResources dut_i (
		.CLK(CLK),
		.arstN(arstN),
		.addr(addr),
		.cpuDout(cpuDout),
		.cpuDin(cpuDin),
		.rdN(rdN),
		.wr0N(wr0N),
		.wr1N(wr1N),
		.dinBus(dinBus),
		.dinGpio(dinGpio),
		.rdGpio(rdGpio),
		.wrGpio(wrGpio),
		.addrGpio(addrGpio),
		.uartRxd(uartLine),
		.uartTxd(uartLine),
		.ints(ints),
		.int0(int0),
		.int1(int1)
	);

	task automatic checkWord(input string name, input logic [15:0] expected,
			input logic [15:0] actual);
		if (actual !== expected) begin
			$display("ERR %s expected %h actual %h", name, expected, actual);
			$display("tests failed");
			$fatal(1, "read data mismatch");
		end
	endtask

	task automatic checkIrq(input string name, input logic [1:0] expected,
			input logic [1:0] actual);
		if (actual !== expected) begin
			$display("ERR %s expected %b actual %b", name, expected, actual);
			$display("tests failed");
			$fatal(1, "interrupt output mismatch");
		end
	endtask

	task automatic checkGpio(input string name, input mcuPkg::periphReq_t expected,
			input mcuPkg::periphReq_t actual);
		if (actual !== expected) begin
			$display("ERR %s expected %h actual %h", name, expected, actual);
			$display("tests failed");
			$fatal(1, "GPIO strobe mismatch");
		end
	endtask

	// GPIO window is page 0xF, block 2
	function automatic mcuPkg::periphReq_t expectedGpio(input logic [15:0] a,
			input logic rd, input logic wr);
		mcuPkg::periphReq_t r;
		logic hit;
		hit = (a[15:12] == 4'hF) && (a[7:4] == 4'h2);
		r.rd = hit && rd;
		r.wr = hit && wr;
		r.addr = a[1:0];
		return r;
	endfunction

	// Strobes low for exactly one sampling edge
	task automatic busWrite(input string name, input logic [15:0] a, input logic [15:0] d,
			input logic [1:0] lanes);
		@(posedge CLK);
		addr <= a;
		cpuDout <= d;
		wr0N <= !lanes[0];
		wr1N <= !lanes[1];
		@(negedge CLK);
		checkGpio(name, expectedGpio(a, 1'b0, |lanes), {rdGpio, wrGpio, addrGpio});
		@(posedge CLK);
		wr0N <= 1'b1;
		wr1N <= 1'b1;
	endtask

	// Data is taken at the falling edge after the sampling edge
	task automatic busRead(input string name, input logic [15:0] a, output logic [15:0] d);
		@(posedge CLK);
		addr <= a;
		rdN <= 1'b0;
		@(negedge CLK);
		checkGpio(name, expectedGpio(a, 1'b1, 1'b0), {rdGpio, wrGpio, addrGpio});
		@(posedge CLK);
		rdN <= 1'b1;
		@(negedge CLK);
		d = cpuDin;
	endtask

	task automatic pollRead(input string name, input logic [15:0] a,
			input logic [15:0] expected);
		logic [15:0] d;
		busRead(name, a, d);
		while (d !== expected) begin
			busRead(name, a, d);
		end
	endtask

	task automatic runOp(input stimOp_t s, input int idx);
		op_t op;
		string name;
		logic [15:0] d;
		op = op_t'(s.op);
		name = $sformatf("%s step %0d", op.name(), idx);
		case (op)
			OP_WR_WORD: busWrite(name, s.addr, s.data, 2'b11);
			OP_WR_LOW: busWrite(name, s.addr, s.data, 2'b01);
			OP_WR_HIGH: busWrite(name, s.addr, s.data, 2'b10);
			OP_READ: begin
				busRead(name, s.addr, d);
				checkWord(name, s.expected, d);
			end
			OP_SET_INTS: begin
				@(posedge CLK);
				ints <= s.data[6:0];
			end
			OP_SET_EXT: begin
				@(posedge CLK);
				dinGpio <= s.data;
				dinBus <= s.expected;
			end
			OP_CHECK_IRQ: begin
				// Pending bits settle one edge after a source change
				@(posedge CLK);
				@(negedge CLK);
				checkIrq(name, s.expected[1:0], {int1, int0});
			end
			OP_WAIT: repeat (int'(s.data)) @(posedge CLK);
			OP_POLL: pollRead(name, s.addr, s.expected);
			default: begin
				$display("unknown operation code %h at stimulus entry %0d", s.op, idx);
				$display("tests failed");
				$fatal(1, "bad stimulus entry");
			end
		endcase
	endtask

	always @(posedge CLK) begin
		cycles <= cycles + 1;
		if (cycleLimit != 0 && cycles >= cycleLimit) begin
			$display("timeout: stimulus did not finish within %0d cycles", cycleLimit);
			$display("tests failed");
			$fatal(1, "timeout");
		end
	end

	initial begin
		int nOps;
		addr = '0;
		cpuDout = '0;
		rdN = 1'b1;
		wr0N = 1'b1;
		wr1N = 1'b1;
		dinBus = '0;
		dinGpio = '0;
		ints = '0;

		// Unused entries read as end markers
		for (int i = 0; i < MAX_OPS; i++) begin
			stimMem[i] = '0;
		end
		$readmemh("dv/mcuStimulus.txt", stimMem);
		nOps = 0;
		while (nOps < MAX_OPS && stimMem[nOps][$bits(stimOp_t)-1 -: 4] != 4'd0) begin
			nOps++;
		end
		cycleLimit = (nOps + 1) * CYCLES_PER_OP;

		@(posedge arstN);
		@(posedge CLK);
		for (int i = 0; i < nOps; i++) begin
			runOp(stimOp_t'(stimMem[i]), i);
		end
		repeat (2) @(posedge CLK);

		if (nOps == 0) begin
			$display("no operations found in the stimulus file");
			$display("tests failed");
			$fatal(1, "empty stimulus");
		end else begin
			$display("all tests passed");
			$finish;
		end
	end

endmodule

// File: dv/mcuStimulus.txt
// op_addr_data_expected in hex; op 1 word write, 2 low byte, 3 high byte, 4 read, 9 poll
// 5 ints=data, 6 dinGpio=data dinBus=expected, 7 expected={int1,int0}, 8 wait data cycles, 0 end
4_0000_0000_A5C3
4_0005_0000_A0C6
4_002A_0000_8FE9
4_003F_0000_9AFC
1_1003_1234_0000
1_10FE_BEEF_0000
4_1003_0000_1234
4_10FE_0000_BEEF
2_1003_77CD_0000
4_1003_0000_12CD
3_1003_AB99_0000
4_1003_0000_ABCD
1_F011_0004_0000
5_0000_0023_0000
7_0000_0000_0001
4_F010_0000_0011
5_0000_0028_0000
7_0000_0000_0002
1_F010_0004_0000
7_0000_0000_0000
4_F010_0000_0011
1_F010_007F_0000
1_F011_0040_0000
8_0000_0004_0000
7_0000_0000_0000
1_F000_005A_0000
9_F001_0000_0002
7_0000_0000_0002
4_F010_0000_0040
4_F000_0000_005A
4_F001_0000_0000
1_F010_0040_0000
7_0000_0000_0000
6_0000_C35A_7E81
4_F020_0000_C35A
4_8000_0000_7E81
4_F030_0000_7E81
0_0000_0000_0000

// File: dv/tbClock.sv
module tbClock (
	output logic CLK,
	output logic arstN
);

	timeunit 1ns;
	timeprecision 100ps;

	// 20 ns period
	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	// Reset held for two rising edges
	initial begin
		arstN = 1'b0;
		repeat (2) @(posedge CLK);
		arstN <= 1'b1;
	end

endmodule

// File: tb.f
verilog/mcuPkg.sv
verilog/memoryMapper.sv
verilog/progRom.sv
verilog/dataRam.sv
verilog/uart.sv
verilog/interruptController.sv
verilog/mcuResources.sv
dv/tbClock.sv
dv/mcuResourcesTb.sv

// File: verilog/dataRam.sv
module dataRam (
	input logic CLK,
	input mcuPkg::ramReq_t req,
	input logic [15:0] wdata,
	output logic [15:0] q
);

	logic [15:0] mem [mcuPkg::RAM_WORDS];

	// Byte lanes are written independently
	always_ff @(posedge CLK) begin
		if (req.en && req.we) begin
			if (req.byteEn[0]) begin
				mem[req.wordAddr][7:0] <= wdata[7:0];
			end
			if (req.byteEn[1]) begin
				mem[req.wordAddr][15:8] <= wdata[15:8];
			end
		end
	end

	// Read port holds its word until the next enabled cycle
	always_ff @(posedge CLK) begin
		if (req.en) begin
			q <= mem[req.wordAddr];
		end
	end

endmodule

// File: verilog/interruptController.sv
module interruptController (
	input logic CLK,
	input logic arstN,
	input mcuPkg::periphReq_t req,
	input logic [7:0] wdata,
	input logic [mcuPkg::INT_SOURCES-1:0] sources,
	output logic [15:0] rdata,
	output logic irq
);

	logic [mcuPkg::INT_SOURCES-1:0] srcQ;
	logic [mcuPkg::INT_SOURCES-1:0] rising;
	logic [mcuPkg::INT_SOURCES-1:0] clearBits;
	logic [mcuPkg::INT_SOURCES-1:0] pending;
	logic [mcuPkg::INT_SOURCES-1:0] mask;
	logic maskWrite;

	assign rising = sources & ~srcQ;
	assign maskWrite = req.wr && (req.addr == mcuPkg::INT_REG_MASK);

	// Write one to clear
	assign clearBits = (req.wr && (req.addr == mcuPkg::INT_REG_PENDING)) ?
		wdata[mcuPkg::INT_SOURCES-1:0] : '0;

	// A new edge wins over a clear in the same cycle
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			srcQ <= '0;
			pending <= '0;
			mask <= '0;
		end else begin
			srcQ <= sources;
			pending <= (pending & ~clearBits) | rising;
			if (maskWrite) begin
				mask <= wdata[mcuPkg::INT_SOURCES-1:0];
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (req.rd) begin
			case (req.addr)
				mcuPkg::INT_REG_PENDING: rdata <= 16'(pending);
				mcuPkg::INT_REG_MASK: rdata <= 16'(mask);
				default: rdata <= '0;
			endcase
		end
	end

	assign irq = |(pending & mask);

	// Only the pending and mask registers take writes
	assert property (@(posedge CLK) disable iff (!arstN)
		req.wr |-> (req.addr == mcuPkg::INT_REG_PENDING ||
			req.addr == mcuPkg::INT_REG_MASK))
		else $error("interruptController: write to an undefined register");

endmodule

// File: verilog/mcuPkg.sv
package mcuPkg;

	// Memory depths and the word address widths that follow from them
	localparam int ROM_WORDS = 64;
	localparam int RAM_WORDS = 256;
	localparam int ROM_ADDR_W = $clog2(ROM_WORDS);
	localparam int RAM_ADDR_W = $clog2(RAM_WORDS);

	// ROM word i holds (i * stride) ^ seed
	localparam logic [15:0] ROM_STRIDE = 16'h0101;
	localparam logic [15:0] ROM_SEED = 16'hA5C3;

	// Page select on addr[15:12]
	localparam logic [3:0] SEL_ROM = 4'h0;
	localparam logic [3:0] SEL_RAM = 4'h1;
	localparam logic [3:0] SEL_PERIPH = 4'hF;

	// Peripheral select on addr[7:4] inside the peripheral page
	localparam logic [3:0] PERIPH_UART = 4'h0;
	localparam logic [3:0] PERIPH_INT = 4'h1;
	localparam logic [3:0] PERIPH_GPIO = 4'h2;

	typedef enum logic [2:0] {
		REGION_ROM,
		REGION_RAM,
		REGION_UART,
		REGION_INT,
		REGION_GPIO,
		REGION_NONE
	} busRegion_t;

	typedef struct packed {
		logic en;
		logic we;
		logic [1:0] byteEn;
		logic [RAM_ADDR_W-1:0] wordAddr;
	} ramReq_t;

	typedef struct packed {
		logic rd;
		logic wr;
		logic [1:0] addr;
	} periphReq_t;

	// Register offsets inside the peripherals
	localparam logic [1:0] UART_REG_DATA = 2'd0;
	localparam logic [1:0] UART_REG_STATUS = 2'd1;
	localparam logic [1:0] INT_REG_PENDING = 2'd0;
	localparam logic [1:0] INT_REG_MASK = 2'd1;

	// UART framing, 8N1 with a short bit period
	localparam int UART_CLKS_PER_BIT = 8;
	localparam int UART_DATA_BITS = 8;
	localparam int UART_CNT_W = $clog2(UART_CLKS_PER_BIT);
	localparam int UART_BIT_W = $clog2(UART_DATA_BITS);

	typedef logic [UART_CNT_W-1:0] uartCnt_t;
	typedef logic [UART_BIT_W-1:0] uartBit_t;

	localparam uartCnt_t UART_BIT_END = uartCnt_t'(UART_CLKS_PER_BIT - 1);
	localparam uartCnt_t UART_MID_END = uartCnt_t'(UART_CLKS_PER_BIT / 2 - 1);
	localparam uartBit_t UART_LAST_BIT = uartBit_t'(UART_DATA_BITS - 1);

	typedef enum logic [1:0] {
		UART_IDLE,
		UART_START,
		UART_DATA,
		UART_STOP
	} uartState_t;

	// Sources masked into int1, the UART receive interrupt is the top one
	localparam int INT_SOURCES = 7;

endpackage

// File: verilog/mcuResources.sv
module mcuResources (
	input logic CLK,
	input logic arstN,

	// CPU bus
	input logic [15:0] addr,
	input logic [15:0] cpuDout,
	output logic [15:0] cpuDin,
	input logic rdN,
	input logic wr0N,
	input logic wr1N,

	// Read data from the external bus for unmapped addresses
	input logic [15:0] dinBus,

	// GPIO window
	input logic [15:0] dinGpio,
	output logic rdGpio,
	output logic wrGpio,
	output logic [1:0] addrGpio,

	input logic uartRxd,
	output logic uartTxd,

	// Interrupts
	input logic [6:0] ints,
	output logic int0,
	output logic int1
);

	mcuPkg::ramReq_t ramReq;
	mcuPkg::periphReq_t uartReq;
	mcuPkg::periphReq_t intReq;
	mcuPkg::periphReq_t gpioReq;
	logic [15:0] dinRom;
	logic [15:0] dinRam;
	logic [15:0] dinUart;
	logic [15:0] dinInt;
	logic uartIrq;

	memoryMapper memoryMapper_i (
		.CLK(CLK),
		.arstN(arstN),
		.addr(addr),
		.rdN(rdN),
		.wr0N(wr0N),
		.wr1N(wr1N),
		.dinBus(dinBus),
		.dinRom(dinRom),
		.dinRam(dinRam),
		.dinUart(dinUart),
		.dinInt(dinInt),
		.dinGpio(dinGpio),
		.ramReq(ramReq),
		.uartReq(uartReq),
		.intReq(intReq),
		.gpioReq(gpioReq),
		.cpuDin(cpuDin)
	);

	progRom progRom_i (
		.CLK(CLK),
		.wordAddr(addr[mcuPkg::ROM_ADDR_W-1:0]),
		.q(dinRom)
	);

	dataRam dataRam_i (
		.CLK(CLK),
		.req(ramReq),
		.wdata(cpuDout),
		.q(dinRam)
	);

	uart uart_i (
		.CLK(CLK),
		.arstN(arstN),
		.req(uartReq),
		.wdata(cpuDout[7:0]),
		.rxd(uartRxd),
		.rdata(dinUart),
		.txd(uartTxd),
		.rxIrq(uartIrq)
	);

	// UART receive takes the seventh source slot
	interruptController interruptController_i (
		.CLK(CLK),
		.arstN(arstN),
		.req(intReq),
		.wdata(cpuDout[7:0]),
		.sources({uartIrq, ints[6:1]}),
		.rdata(dinInt),
		.irq(int1)
	);

	assign rdGpio = gpioReq.rd;
	assign wrGpio = gpioReq.wr;
	assign addrGpio = gpioReq.addr;

	// Source 0 bypasses the controller
	assign int0 = ints[0];

endmodule

// File: verilog/memoryMapper.sv
module memoryMapper (
	input logic CLK,
	input logic arstN,
	input logic [15:0] addr,
	input logic rdN,
	input logic wr0N,
	input logic wr1N,
	input logic [15:0] dinBus,
	input logic [15:0] dinRom,
	input logic [15:0] dinRam,
	input logic [15:0] dinUart,
	input logic [15:0] dinInt,
	input logic [15:0] dinGpio,
	output mcuPkg::ramReq_t ramReq,
	output mcuPkg::periphReq_t uartReq,
	output mcuPkg::periphReq_t intReq,
	output mcuPkg::periphReq_t gpioReq,
	output logic [15:0] cpuDin
);

	mcuPkg::busRegion_t region;
	mcuPkg::busRegion_t regionQ;
	logic rd;
	logic wr;
	logic [15:0] extQ;

	function automatic mcuPkg::periphReq_t makeReq(input logic sel, input logic rdEn,
			input logic wrEn, input logic [1:0] regAddr);
		mcuPkg::periphReq_t r;
		r.rd = sel && rdEn;
		r.wr = sel && wrEn;
		r.addr = regAddr;
		return r;
	endfunction

	assign rd = !rdN;
	assign wr = !wr0N || !wr1N;

	// Page decode, ROM aliases across the whole low page
	always_comb begin
		case (addr[15:12])
			mcuPkg::SEL_ROM: region = mcuPkg::REGION_ROM;
			mcuPkg::SEL_RAM: region = mcuPkg::REGION_RAM;
			mcuPkg::SEL_PERIPH: begin
				case (addr[7:4])
					mcuPkg::PERIPH_UART: region = mcuPkg::REGION_UART;
					mcuPkg::PERIPH_INT: region = mcuPkg::REGION_INT;
					mcuPkg::PERIPH_GPIO: region = mcuPkg::REGION_GPIO;
					default: region = mcuPkg::REGION_NONE;
				endcase
			end
			default: region = mcuPkg::REGION_NONE;
		endcase
	end

	assign ramReq.en = (region == mcuPkg::REGION_RAM) && (rd || wr);
	assign ramReq.we = (region == mcuPkg::REGION_RAM) && wr;
	assign ramReq.byteEn = {!wr1N, !wr0N};
	assign ramReq.wordAddr = addr[mcuPkg::RAM_ADDR_W-1:0];

	assign uartReq = makeReq(region == mcuPkg::REGION_UART, rd, wr, addr[1:0]);
	assign intReq = makeReq(region == mcuPkg::REGION_INT, rd, wr, addr[1:0]);
	assign gpioReq = makeReq(region == mcuPkg::REGION_GPIO, rd, wr, addr[1:0]);

	// Region of the last read steers the return mux during the next cycle
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			regionQ <= mcuPkg::REGION_NONE;
		end else if (rd) begin
			regionQ <= region;
		end
	end

	// External words get the same one-cycle latency as the internal blocks
	always_ff @(posedge CLK) begin
		if (rd) begin
			extQ <= (region == mcuPkg::REGION_GPIO) ? dinGpio : dinBus;
		end
	end

	always_comb begin
		case (regionQ)
			mcuPkg::REGION_ROM: cpuDin = dinRom;
			mcuPkg::REGION_RAM: cpuDin = dinRam;
			mcuPkg::REGION_UART: cpuDin = dinUart;
			mcuPkg::REGION_INT: cpuDin = dinInt;
			default: cpuDin = extQ;
		endcase
	end

	// The CPU never reads and writes in the same cycle
	assert property (@(posedge CLK) disable iff (!arstN) !(rd && wr))
		else $error("memoryMapper: read and write strobes active together");

endmodule

// File: verilog/progRom.sv
module progRom (
	input logic CLK,
	input logic [mcuPkg::ROM_ADDR_W-1:0] wordAddr,
	output logic [15:0] q
);

	logic [15:0] romTable [mcuPkg::ROM_WORDS];

	// Constant contents, every word is distinct and easy to predict
	for (genvar i = 0; i < mcuPkg::ROM_WORDS; i++) begin : genTable
		assign romTable[i] = (16'(i) * mcuPkg::ROM_STRIDE) ^ mcuPkg::ROM_SEED;
	end

	// Registered output gives the one-cycle read latency of the bus
	always_ff @(posedge CLK) begin
		q <= romTable[wordAddr];
	end

endmodule

// File: verilog/uart.sv
module uart (
	input logic CLK,
	input logic arstN,
	input mcuPkg::periphReq_t req,
	input logic [7:0] wdata,
	input logic rxd,
	output logic [15:0] rdata,
	output logic txd,
	output logic rxIrq
);

	mcuPkg::uartState_t txState;
	mcuPkg::uartCnt_t txCnt;
	mcuPkg::uartBit_t txBit;
	logic [mcuPkg::UART_DATA_BITS-1:0] txShift;
	logic txBusy;
	logic txStart;

	mcuPkg::uartState_t rxState;
	mcuPkg::uartCnt_t rxCnt;
	mcuPkg::uartBit_t rxBit;
	logic [mcuPkg::UART_DATA_BITS-1:0] rxShift;
	logic [mcuPkg::UART_DATA_BITS-1:0] rxData;
	logic [1:0] rxSync;
	logic rxValid;
	logic dataRead;

	assign txBusy = txState != mcuPkg::UART_IDLE;
	assign txStart = req.wr && (req.addr == mcuPkg::UART_REG_DATA) && !txBusy;
	assign dataRead = req.rd && (req.addr == mcuPkg::UART_REG_DATA);

	// Transmitter, one bit period per count wrap
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			txState <= mcuPkg::UART_IDLE;
			txCnt <= '0;
			txBit <= '0;
			txShift <= '0;
		end else if (txState == mcuPkg::UART_IDLE) begin
			if (txStart) begin
				txShift <= wdata;
				txCnt <= '0;
				txState <= mcuPkg::UART_START;
			end
		end else if (txCnt != mcuPkg::UART_BIT_END) begin
			txCnt <= txCnt + 1'b1;
		end else begin
			txCnt <= '0;
			case (txState)
				mcuPkg::UART_START: begin
					txBit <= '0;
					txState <= mcuPkg::UART_DATA;
				end
				mcuPkg::UART_DATA: begin
					txShift <= txShift >> 1;
					txBit <= txBit + 1'b1;
					if (txBit == mcuPkg::UART_LAST_BIT) begin
						txState <= mcuPkg::UART_STOP;
					end
				end
				default: txState <= mcuPkg::UART_IDLE;
			endcase
		end
	end

	always_comb begin
		case (txState)
			mcuPkg::UART_START: txd = 1'b0;
			mcuPkg::UART_DATA: txd = txShift[0];
			default: txd = 1'b1;
		endcase
	end

	// Receiver samples at mid-bit, counted from the start bit center
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			rxSync <= 2'b11;
			rxState <= mcuPkg::UART_IDLE;
			rxCnt <= '0;
			rxBit <= '0;
			rxShift <= '0;
			rxData <= '0;
			rxValid <= 1'b0;
		end else begin
			rxSync <= {rxSync[0], rxd};
			if (dataRead) begin
				rxValid <= 1'b0;
			end
			case (rxState)
				mcuPkg::UART_IDLE: begin
					if (!rxSync[1]) begin
						rxCnt <= '0;
						rxState <= mcuPkg::UART_START;
					end
				end
				mcuPkg::UART_START: begin
					if (rxCnt == mcuPkg::UART_MID_END) begin
						rxCnt <= '0;
						rxBit <= '0;
						// Line back high means a glitch, not a start bit
						rxState <= rxSync[1] ? mcuPkg::UART_IDLE : mcuPkg::UART_DATA;
					end else begin
						rxCnt <= rxCnt + 1'b1;
					end
				end
				mcuPkg::UART_DATA: begin
					if (rxCnt == mcuPkg::UART_BIT_END) begin
						rxCnt <= '0;
						rxShift <= {rxSync[1], rxShift[mcuPkg::UART_DATA_BITS-1:1]};
						rxBit <= rxBit + 1'b1;
						if (rxBit == mcuPkg::UART_LAST_BIT) begin
							rxState <= mcuPkg::UART_STOP;
						end
					end else begin
						rxCnt <= rxCnt + 1'b1;
					end
				end
				default: begin
					if (rxCnt == mcuPkg::UART_BIT_END) begin
						rxCnt <= '0;
						rxData <= rxShift;
						rxValid <= 1'b1;
						rxState <= mcuPkg::UART_IDLE;
					end else begin
						rxCnt <= rxCnt + 1'b1;
					end
				end
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (req.rd) begin
			case (req.addr)
				mcuPkg::UART_REG_DATA: rdata <= 16'(rxData);
				mcuPkg::UART_REG_STATUS: rdata <= {14'd0, rxValid, txBusy};
				default: rdata <= '0;
			endcase
		end
	end

	assign rxIrq = rxValid;

	// No back-pressure, so a write during transmission is lost
	assert property (@(posedge CLK) disable iff (!arstN)
		!(req.wr && (req.addr == mcuPkg::UART_REG_DATA) && txBusy))
		else $error("uart: data write dropped while transmitter busy");

endmodule
